// File: dv/fft_depkt_tb.sv
/*
 * Testbench for the FFT depacketizer: drives bursts, symbols and FFT data
 * and checks packets and prefix lengths against reference tables
 */

`timescale 1ns/100ps

module fft_depkt_tb
  import fft_depkt_pkg::*;
();

  localparam int          ITEM_W      = 32;
  localparam int          TIMEOUT     = 2000;
  localparam int          MAX_PKTS    = 32;
  localparam int          MAX_CPS     = 16;
  localparam int          READY_BURST = 0;
  localparam int          READY_SYMB  = 1;
  localparam int          READY_FFT   = 2;
  localparam logic [31:0] SEED        = 32'haf4a6574;

  logic                       clk = 1'b0;
  logic                       rst;
  logic [FFT_SIZE_LOG2_W-1:0] i_fft_size_log2;
  burst_info_t                i_burst;
  logic                       i_burst_valid;
  logic                       o_burst_ready;
  symbol_info_t               i_symbol;
  logic                       i_symbol_valid;
  logic                       o_symbol_ready;
  logic [CP_LEN_W-1:0]        i_cp_len;
  logic                       i_cp_valid;
  logic                       o_cp_ready;
  logic [CP_LEN_W-1:0]        o_cp_len;
  logic                       o_cp_valid;
  logic                       i_cp_ready = 1'b0;
  logic [ITEM_W-1:0]          i_fft_data;
  logic                       i_fft_last;
  logic                       i_fft_valid;
  logic                       o_fft_ready;
  logic [ITEM_W-1:0]          o_noc_data;
  logic                       o_noc_last;
  logic                       o_noc_valid;
  logic                       i_noc_ready = 1'b0;
  noc_meta_t                  o_noc_meta;

  // Reference tables are filled for a burst before any of its data moves
  noc_meta_t           ref_meta [MAX_PKTS];
  int                  ref_items [MAX_PKTS];
  logic [CP_LEN_W-1:0] ref_cp [MAX_CPS];
  int                  ref_pkts;
  int                  ref_cps;

  // Position of the DUT outputs within the reference tables
  int   pkt_idx;
  int   item_idx;
  int   beat_count;
  int   cp_idx;
  int   fed_count;
  int   errors;
  int   tests_run;
  int   tests_failed;
  logic noc_beat;
  logic cp_beat;

  fft_depkt_top #(
    .ITEM_W (ITEM_W)
  ) dut_i (.*);

  always #5 clk = ~clk;

  assign noc_beat = o_noc_valid && i_noc_ready;
  assign cp_beat  = o_cp_valid && i_cp_ready;

  // ------------------------------------------------------------
  // Output tracking and checks
  // ------------------------------------------------------------

  // Packet boundaries follow the reference item counts
  always @(posedge clk) begin
    if (rst) begin
      pkt_idx    <= 0;
      item_idx   <= 0;
      beat_count <= 0;
      cp_idx     <= 0;
    end else begin
      if (noc_beat) begin
        beat_count <= beat_count + 1;
        if (item_idx == ref_items[pkt_idx] - 1) begin
          pkt_idx  <= pkt_idx + 1;
          item_idx <= 0;
        end else begin
          item_idx <= item_idx + 1;
        end
      end
      if (cp_beat) begin
        cp_idx <= cp_idx + 1;
      end
    end
  end

  a_reset_low: assert property (@(posedge clk)
      rst |=> !(o_burst_ready || o_symbol_ready || o_cp_ready ||
                o_cp_valid || o_noc_valid || o_fft_ready))
    else note_error("handshake output high during reset");

  a_pkt_count: assert property (@(posedge clk) disable iff (rst)
      noc_beat |-> pkt_idx < ref_pkts)
    else note_error("packet beat beyond the expected packets");

  a_data: assert property (@(posedge clk) disable iff (rst)
      noc_beat |-> o_noc_data == ITEM_W'(beat_count))
    else note_error("packet data out of order");

  a_last: assert property (@(posedge clk) disable iff (rst)
      noc_beat |-> o_noc_last == (item_idx == ref_items[pkt_idx] - 1))
    else note_error("last flag on the wrong beat");

  // Checked on every beat, so it also covers stability within a packet
  a_meta: assert property (@(posedge clk) disable iff (rst)
      noc_beat |-> o_noc_meta == ref_meta[pkt_idx])
    else note_error("packet metadata mismatch");

  a_cp: assert property (@(posedge clk) disable iff (rst)
      cp_beat |-> (cp_idx < ref_cps) && (o_cp_len == ref_cp[cp_idx]))
    else note_error("prefix length out of order");

  // The input prefix is consumed in the one cycle after its symbol is taken
  a_cp_ready: assert property (@(posedge clk) disable iff (rst)
      o_cp_ready == $past(i_symbol_valid && o_symbol_ready))
    else note_error("prefix ready pulse on the wrong cycle");

  // Random downstream stalls and prefix consumer for the whole run
  always @(posedge clk) begin
    #1;
    i_noc_ready = ($urandom_range(3) != 0);
    i_cp_ready  = ($urandom_range(1) == 1);
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  task automatic note_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic abort_run(input string what);
    $display("Timed out waiting for %s", what);
    $display("Test failures found");
    $finish;
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic logic ready_of(input int which);
    case (which)
      READY_BURST: return o_burst_ready;
      READY_SYMB:  return o_symbol_ready;
      default:     return o_fft_ready;
    endcase
  endfunction

  // Ready is looked at one ns after the drive, then the handshake edge passes
  task automatic wait_for_ready(input int which, input string what);
    int waited;
    waited = 0;
    #1;
    while (!ready_of(which)) begin
      waited++;
      if (waited > TIMEOUT) abort_run(what);
      @(posedge clk);
      #2;
    end
    step();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %0d %s: PASS", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL (%0d errors)", tests_run, name, errors - errs_before);
    end
  endtask

  // Fills the reference for one burst, then drives burst, symbols and FFT items
  task automatic run_burst(input int fft_log2, input int pkt_size, input int nsym,
                           input int cp_base, input int cp_step,
                           input logic [TIMESTAMP_W-1:0] ts, input logic has_time);
    int fft_len;
    int total;
    int sent;
    int n;
    int waited;
    fft_len = 1 << fft_log2;
    total   = 0;
    for (int k = 0; k < nsym; k++) begin
      ref_cp[ref_cps] = CP_LEN_W'(cp_base + k * cp_step);
      ref_cps++;
      total += fft_len + cp_base + k * cp_step;
    end
    // Packets are packet-size chunks of the burst total with the remainder last
    sent = 0;
    while (sent < total) begin
      n = (total - sent > pkt_size) ? pkt_size : total - sent;
      ref_items[ref_pkts]          = n;
      ref_meta[ref_pkts].length    = LENGTH_W'(n * (ITEM_W / 8));
      ref_meta[ref_pkts].timestamp = ts + TIMESTAMP_W'(sent);
      ref_meta[ref_pkts].has_time  = has_time;
      sent += n;
      ref_meta[ref_pkts].eov       = (sent % fft_len == 0);
      ref_meta[ref_pkts].eob       = (sent == total);
      ref_pkts++;
    end
    // The size register takes two cycles to settle
    i_fft_size_log2 = FFT_SIZE_LOG2_W'(fft_log2);
    repeat (3) step();
    i_burst       = '{pkt_size: PKT_SIZE_W'(pkt_size), timestamp: ts, has_time: has_time};
    i_burst_valid = 1'b1;
    wait_for_ready(READY_BURST, "burst handshake");
    i_burst_valid = 1'b0;
    for (int k = 0; k < nsym; k++) begin
      i_symbol.last  = (k == nsym - 1);
      i_cp_len       = CP_LEN_W'(cp_base + k * cp_step);
      i_cp_valid     = 1'b1;
      i_symbol_valid = 1'b1;
      wait_for_ready(READY_SYMB, "symbol handshake");
      i_symbol_valid = 1'b0;
    end
    i_cp_valid = 1'b0;
    // FFT items are a running counter with an idle cycle now and then
    for (int k = 0; k < total; k++) begin
      if ($urandom_range(3) == 0) begin
        i_fft_valid = 1'b0;
        step();
      end
      i_fft_data  = ITEM_W'(fed_count);
      i_fft_valid = 1'b1;
      wait_for_ready(READY_FFT, "FFT input ready");
      fed_count++;
    end
    i_fft_valid = 1'b0;
    waited      = 0;
    while (pkt_idx != ref_pkts || cp_idx != ref_cps) begin
      waited++;
      if (waited > TIMEOUT) abort_run("the remaining packets and prefix lengths");
      step();
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    int errs_before;
    void'($urandom(SEED));
    rst             = 1'b1;
    i_fft_size_log2 = '0;
    i_burst         = '0;
    i_burst_valid   = 1'b0;
    i_symbol        = '0;
    i_symbol_valid  = 1'b0;
    i_cp_len        = '0;
    i_cp_valid      = 1'b0;
    i_fft_data      = '0;
    i_fft_last      = 1'b0;
    i_fft_valid     = 1'b0;
    ref_pkts        = 0;
    ref_cps         = 0;
    fed_count       = 0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    step();
    finish_test("reset outputs", 0);

    errs_before = errors;
    run_burst(4, 16, 2, 0, 0, 64'd1000, 1'b1);
    finish_test("no prefix", errs_before);

    errs_before = errors;
    run_burst(4, 8, 3, 4, 0, 64'h1_0000_0040, 1'b0);
    finish_test("with prefix", errs_before);

    // Unequal prefixes make the prefix order visible
    errs_before = errors;
    run_burst(5, 24, 4, 1, 2, 64'd777, 1'b1);
    finish_test("varying prefix under stalls", errs_before);

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: fft_depkt.f
src/fft_depkt_pkg.sv
src/fft_depkt_fifo.sv
src/fft_symbol_sizer.sv
src/fft_pkt_resizer.sv
src/fft_depkt_top.sv
dv/fft_depkt_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the FFT depacketizer testbench with Verilator, runs it and
# judges the result from the simulation log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fft_depkt_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module fft_depkt_tb -f fft_depkt.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
exit 0

// File: src/fft_depkt_fifo.sv
/*
 * Synchronous FIFO with first-word-fall-through output and valid/ready
 * handshakes on both the write and the read side
 */

`timescale 1ns/100ps

module fft_depkt_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_LOG2 = 5
) (
  input  logic             clk,
  input  logic             rst,
  // Write side
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_valid,
  output logic             o_in_ready,
  // Read side, head of the queue is always visible
  output logic [WIDTH-1:0] o_data,
  output logic             o_valid,
  input  logic             i_ready
);

  localparam int DEPTH = 2**DEPTH_LOG2;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  // Fill level, one bit wider than the pointers so full can be told from empty
  logic [DEPTH_LOG2:0]   count;
  logic                  wr_en;
  logic                  rd_en;

  // The top bit of count is only set when all DEPTH slots are taken
  assign o_in_ready = !count[DEPTH_LOG2];
  assign o_valid    = (count != '0);
  assign o_data     = mem[rd_ptr];

  assign wr_en = i_valid && o_in_ready;
  assign rd_en = o_valid && i_ready;

  // Storage array
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the level unchanged
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/fft_depkt_pkg.sv
/*
 * FFT depacketizer package: size constants and the sideband structs for
 * bursts, symbols, queued symbol entries and outgoing packet metadata
 */

package fft_depkt_pkg;

  // ------------------------------------------------------------
  // Size constants
  // ------------------------------------------------------------

  // Largest packet is 2**11 items and largest FFT is 2**10 items
  localparam int MAX_PKT_SIZE_LOG2 = 11;
  localparam int MAX_FFT_SIZE_LOG2 = 10;

  // One extra bit so the maximum size itself fits
  localparam int PKT_SIZE_W = MAX_PKT_SIZE_LOG2 + 1;

  // A symbol may be an FFT plus a prefix of almost the same size
  localparam int FFT_SIZE_W = MAX_FFT_SIZE_LOG2 + 2;

  // Width of the log2 FFT size, enough to hold MAX_FFT_SIZE_LOG2
  localparam int FFT_SIZE_LOG2_W = $clog2(MAX_FFT_SIZE_LOG2 + 1);

  // Prefix is always shorter than the largest FFT
  localparam int CP_LEN_W = MAX_FFT_SIZE_LOG2;

  localparam int TIMESTAMP_W = 64;
  localparam int LENGTH_W    = 16;

  // ------------------------------------------------------------
  // Sideband structs
  // ------------------------------------------------------------

  // Burst setup from the packetizer side
  typedef struct packed {
    logic [PKT_SIZE_W-1:0]  pkt_size;   // Packet size in items
    logic [TIMESTAMP_W-1:0] timestamp;  // Time of the first item of the burst
    logic                   has_time;
  } burst_info_t;

  // Per-symbol flag from the packetizer
  typedef struct packed {
    logic last;  // Symbol closes the burst
  } symbol_info_t;

  // Entry queued between the symbol sizer and the packet resizer
  typedef struct packed {
    logic                  last;
    logic [FFT_SIZE_W-1:0] length;  // FFT size plus prefix, in items
  } symbol_entry_t;

  // Metadata for the packet currently on the output bus
  typedef struct packed {
    logic [LENGTH_W-1:0]    length;  // Payload length in bytes
    logic [TIMESTAMP_W-1:0] timestamp;
    logic                   has_time;
    logic                   eov;
    logic                   eob;
  } noc_meta_t;

endpackage

// File: src/fft_depkt_top.sv
/*
 * FFT output depacketizer: registers the FFT size and joins the symbol
 * sizer to the packet resizer
 */

`timescale 1ns/100ps

module fft_depkt_top
  import fft_depkt_pkg::*;
#(
  parameter int ITEM_W               = 32,
  parameter int SYMB_FIFO_DEPTH_LOG2 = 5,
  parameter int CP_FIFO_DEPTH_LOG2   = 5
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [FFT_SIZE_LOG2_W-1:0] i_fft_size_log2,
  input  burst_info_t                i_burst,
  input  logic                       i_burst_valid,
  output logic                       o_burst_ready,
  input  symbol_info_t               i_symbol,
  input  logic                       i_symbol_valid,
  output logic                       o_symbol_ready,
  // Prefix input has no valid in use, the prefix must be present with its symbol
  input  logic [CP_LEN_W-1:0]        i_cp_len,
  input  logic                       i_cp_valid,
  output logic                       o_cp_ready,
  output logic [CP_LEN_W-1:0]        o_cp_len,
  output logic                       o_cp_valid,
  input  logic                       i_cp_ready,
  // Packet boundaries come from the resizer, so i_fft_last is not needed
  input  logic [ITEM_W-1:0]          i_fft_data,
  input  logic                       i_fft_last,
  input  logic                       i_fft_valid,
  output logic                       o_fft_ready,
  output logic [ITEM_W-1:0]          o_noc_data,
  output logic                       o_noc_last,
  output logic                       o_noc_valid,
  input  logic                       i_noc_ready,
  output noc_meta_t                  o_noc_meta
);

  logic [FFT_SIZE_LOG2_W-1:0] fft_size_log2_r;
  logic [FFT_SIZE_W-1:0]      fft_size;
  symbol_entry_t              entry;
  logic                       entry_valid;
  logic                       entry_ready;

  // ------------------------------------------------------------
  // FFT size register
  // ------------------------------------------------------------

  // The size is static during a burst, so two register stages are harmless
  always_ff @(posedge clk) begin
    fft_size_log2_r <= i_fft_size_log2;
    fft_size        <= FFT_SIZE_W'(1) << fft_size_log2_r;
  end

  fft_symbol_sizer #(
    .CP_FIFO_DEPTH_LOG2   (CP_FIFO_DEPTH_LOG2),
    .SYMB_FIFO_DEPTH_LOG2 (SYMB_FIFO_DEPTH_LOG2)
  ) sizer_i (
    .clk            (clk),
    .rst            (rst),
    .i_fft_size     (fft_size),
    .i_symbol       (i_symbol),
    .i_symbol_valid (i_symbol_valid),
    .o_symbol_ready (o_symbol_ready),
    .i_cp_len       (i_cp_len),
    .o_cp_ready     (o_cp_ready),
    .o_cp_len       (o_cp_len),
    .o_cp_valid     (o_cp_valid),
    .i_cp_ready     (i_cp_ready),
    .o_entry        (entry),
    .o_entry_valid  (entry_valid),
    .i_entry_ready  (entry_ready)
  );

  fft_pkt_resizer #(
    .ITEM_W (ITEM_W)
  ) resizer_i (
    .clk           (clk),
    .rst           (rst),
    .i_fft_size    (fft_size),
    .i_burst       (i_burst),
    .i_burst_valid (i_burst_valid),
    .o_burst_ready (o_burst_ready),
    .i_entry       (entry),
    .i_entry_valid (entry_valid),
    .o_entry_ready (entry_ready),
    .i_fft_data    (i_fft_data),
    .i_fft_valid   (i_fft_valid),
    .o_fft_ready   (o_fft_ready),
    .o_noc_data    (o_noc_data),
    .o_noc_last    (o_noc_last),
    .o_noc_valid   (o_noc_valid),
    .i_noc_ready   (i_noc_ready),
    .o_noc_meta    (o_noc_meta)
  );

endmodule

// File: src/fft_pkt_resizer.sv
/*
 * Packet resizer: cuts the symbol-sized FFT output into packets of the
 * burst's packet size and drives length, timestamp, EOV and EOB per packet
 */

`timescale 1ns/100ps

module fft_pkt_resizer
  import fft_depkt_pkg::*;
#(
  parameter int ITEM_W = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [FFT_SIZE_W-1:0] i_fft_size,
  // Burst setup
  input  burst_info_t           i_burst,
  input  logic                  i_burst_valid,
  output logic                  o_burst_ready,
  // Queued symbol entries from the sizer
  input  symbol_entry_t         i_entry,
  input  logic                  i_entry_valid,
  output logic                  o_entry_ready,
  // FFT core output
  input  logic [ITEM_W-1:0]     i_fft_data,
  input  logic                  i_fft_valid,
  output logic                  o_fft_ready,
  // Packet output
  output logic [ITEM_W-1:0]     o_noc_data,
  output logic                  o_noc_last,
  output logic                  o_noc_valid,
  input  logic                  i_noc_ready,
  output noc_meta_t             o_noc_meta
);

  localparam int BYTES_PER_ITEM = ITEM_W / 8;

  // Worst case backlog is just under one packet plus one maximum symbol
  localparam int ITEMS_W = $clog2(2**MAX_PKT_SIZE_LOG2 + 2**(MAX_FFT_SIZE_LOG2 + 1));

  typedef enum logic [2:0] {
    ST_WAIT_BURST,
    ST_CALC_ITEMS,
    ST_CALC_PACKET,
    ST_CALC_VECTOR,
    ST_CALC_EOV,
    ST_PASS_PACKET
  } state_t;

  state_t state;

  // Settings of the current burst
  logic [PKT_SIZE_W-1:0]        pkt_size;
  logic [TIMESTAMP_W-1:0]       timestamp;
  logic                         has_time;
  logic                         last_symbol;

  // Items announced by queued symbols but not yet sent
  logic [ITEMS_W-1:0]           items_to_send;
  // Position within the FFT vector, wraps at the largest FFT size
  logic [MAX_FFT_SIZE_LOG2-1:0] vect_count;
  logic [MAX_FFT_SIZE_LOG2-1:0] fft_mask;

  // Current packet
  logic [PKT_SIZE_W-1:0]        pkt_len;
  logic [PKT_SIZE_W-1:0]        pkt_count;
  logic                         pkt_last;
  noc_meta_t                    pkt_meta;
  logic                         beat;

  // FFT sizes are powers of two, so EOV is a check of the low bits
  assign fft_mask = MAX_FFT_SIZE_LOG2'(i_fft_size - 1'b1);

  assign beat = o_noc_valid && i_noc_ready;

  // ------------------------------------------------------------
  // Packet resize FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    o_burst_ready <= 1'b0;
    o_entry_ready <= 1'b0;

    case (state)
      ST_WAIT_BURST: begin
        items_to_send <= '0;
        vect_count    <= '0;
        o_burst_ready <= 1'b1;
        if (i_burst_valid && o_burst_ready) begin
          o_burst_ready <= 1'b0;
          pkt_size      <= i_burst.pkt_size;
          timestamp     <= i_burst.timestamp;
          has_time      <= i_burst.has_time;
          o_entry_ready <= 1'b1;
          state         <= ST_CALC_ITEMS;
        end
      end

      ST_CALC_ITEMS: begin
        // Pull the next symbol length and add it to the backlog
        o_entry_ready <= 1'b1;
        if (i_entry_valid && o_entry_ready) begin
          o_entry_ready <= 1'b0;
          items_to_send <= items_to_send + ITEMS_W'(i_entry.length);
          last_symbol   <= i_entry.last;
          state         <= ST_CALC_PACKET;
        end
      end

      ST_CALC_PACKET: begin
        // Two ahead: one for the registered last flag, one for the first beat
        pkt_count         <= PKT_SIZE_W'(2);
        pkt_meta.timestamp <= timestamp;
        pkt_meta.has_time  <= has_time;
        if (items_to_send > ITEMS_W'(pkt_size) ||
            (!last_symbol && items_to_send == ITEMS_W'(pkt_size))) begin
          // A full packet, and more of the burst still follows it
          pkt_len      <= pkt_size;
          pkt_meta.eob <= 1'b0;
          state        <= ST_CALC_VECTOR;
        end else if (last_symbol) begin
          // Whatever is left closes the burst
          pkt_len      <= PKT_SIZE_W'(items_to_send);
          pkt_meta.eob <= 1'b1;
          state        <= ST_CALC_VECTOR;
        end else begin
          // Not enough for a packet yet
          o_entry_ready <= 1'b1;
          state         <= ST_CALC_ITEMS;
        end
      end

      ST_CALC_VECTOR: begin
        // Vector position at the end of this packet
        vect_count      <= vect_count + MAX_FFT_SIZE_LOG2'(pkt_len);
        pkt_meta.length <= LENGTH_W'(pkt_len * BYTES_PER_ITEM);
        state           <= ST_CALC_EOV;
      end

      ST_CALC_EOV: begin
        pkt_meta.eov <= ((vect_count & fft_mask) == '0);
        // A one-item packet is last on its first beat
        pkt_last     <= (pkt_len <= PKT_SIZE_W'(1));
        state        <= ST_PASS_PACKET;
      end

      ST_PASS_PACKET: begin
        if (beat) begin
          // Time runs as if the items were contiguous
          timestamp     <= timestamp + 1'b1;
          items_to_send <= items_to_send - 1'b1;
          pkt_count     <= pkt_count + 1'b1;
          pkt_last      <= (pkt_count >= pkt_len);
          if (pkt_last) begin
            state <= pkt_meta.eob ? ST_WAIT_BURST : ST_CALC_PACKET;
          end
        end
      end

      default: state <= ST_WAIT_BURST;
    endcase

    if (rst) begin
      state         <= ST_WAIT_BURST;
      o_burst_ready <= 1'b0;
      o_entry_ready <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Data pass-through
  // ------------------------------------------------------------

  // Data only moves while a packet is open, so back-pressure goes straight
  // through to the FFT core
  assign o_noc_data  = i_fft_data;
  assign o_noc_last  = pkt_last;
  assign o_noc_meta  = pkt_meta;
  assign o_noc_valid = (state == ST_PASS_PACKET) ? i_fft_valid : 1'b0;
  assign o_fft_ready = (state == ST_PASS_PACKET) ? i_noc_ready : 1'b0;

endmodule

// File: src/fft_symbol_sizer.sv
/*
 * Symbol sizer: captures each symbol's last flag and prefix, queues the
 * symbol length for the resizer and the prefix for downstream insertion
 */

`timescale 1ns/100ps

module fft_symbol_sizer
  import fft_depkt_pkg::*;
#(
  parameter int CP_FIFO_DEPTH_LOG2   = 5,
  parameter int SYMB_FIFO_DEPTH_LOG2 = 5
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [FFT_SIZE_W-1:0] i_fft_size,
  // Symbol flags from the packetizer
  input  symbol_info_t          i_symbol,
  input  logic                  i_symbol_valid,
  output logic                  o_symbol_ready,
  // Prefix of the symbol being offered
  input  logic [CP_LEN_W-1:0]   i_cp_len,
  output logic                  o_cp_ready,
  // Prefix copy for the insertion logic
  output logic [CP_LEN_W-1:0]   o_cp_len,
  output logic                  o_cp_valid,
  input  logic                  i_cp_ready,
  // Queued symbol entries for the resizer
  output symbol_entry_t         o_entry,
  output logic                  o_entry_valid,
  input  logic                  i_entry_ready
);

  typedef enum logic [1:0] {
    ST_WAIT,
    ST_CALC,
    ST_PASS
  } state_t;

  state_t                state;
  logic                  last_symbol;
  logic [CP_LEN_W-1:0]   cp_len;
  logic [FFT_SIZE_W-1:0] symbol_size;
  // High for the one cycle after a symbol is taken
  logic                  prefix_stb;
  logic                  entry_push;
  symbol_entry_t         entry_in;
  logic                  symb_fifo_ready;
  logic                  cp_fifo_ready;

  // ------------------------------------------------------------
  // Symbol size FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    // Strobes fall back low unless a state holds them up
    o_symbol_ready <= 1'b0;
    prefix_stb     <= 1'b0;
    entry_push     <= 1'b0;

    case (state)
      ST_WAIT: begin
        // Only take a symbol while both queues can hold one more entry
        o_symbol_ready <= symb_fifo_ready && cp_fifo_ready;
        // The prefix is required to be present with the symbol, so it is
        // sampled together with the flag and needs no valid of its own
        last_symbol <= i_symbol.last;
        cp_len      <= i_cp_len;
        if (i_symbol_valid && o_symbol_ready) begin
          o_symbol_ready <= 1'b0;
          prefix_stb     <= 1'b1;
          state          <= ST_CALC;
        end
      end

      ST_CALC: begin
        // Total items the FFT core emits for this symbol
        symbol_size <= i_fft_size + FFT_SIZE_W'(cp_len);
        entry_push  <= 1'b1;
        state       <= ST_PASS;
      end

      ST_PASS: begin
        // Hold the entry until the symbol FIFO accepts it
        entry_push <= 1'b1;
        if (symb_fifo_ready) begin
          entry_push <= 1'b0;
          state      <= ST_WAIT;
        end
      end

      default: state <= ST_WAIT;
    endcase

    if (rst) begin
      state          <= ST_WAIT;
      o_symbol_ready <= 1'b0;
      prefix_stb     <= 1'b0;
      entry_push     <= 1'b0;
    end
  end

  // Consuming the input prefix and queuing its copy happen together
  assign o_cp_ready = prefix_stb;

  assign entry_in = '{last: last_symbol, length: symbol_size};

  // ------------------------------------------------------------
  // Symbol information and prefix length queues
  // ------------------------------------------------------------

  fft_depkt_fifo #(
    .WIDTH      ($bits(symbol_entry_t)),
    .DEPTH_LOG2 (SYMB_FIFO_DEPTH_LOG2)
  ) symb_fifo_i (
    .clk        (clk),
    .rst        (rst),
    .i_data     (entry_in),
    .i_valid    (entry_push),
    .o_in_ready (symb_fifo_ready),
    .o_data     (o_entry),
    .o_valid    (o_entry_valid),
    .i_ready    (i_entry_ready)
  );

  fft_depkt_fifo #(
    .WIDTH      (CP_LEN_W),
    .DEPTH_LOG2 (CP_FIFO_DEPTH_LOG2)
  ) cp_fifo_i (
    .clk        (clk),
    .rst        (rst),
    .i_data     (cp_len),
    .i_valid    (prefix_stb),
    .o_in_ready (cp_fifo_ready),
    .o_data     (o_cp_len),
    .o_valid    (o_cp_valid),
    .i_ready    (i_cp_ready)
  );

endmodule
